// ==== issue_core.f ====
+incdir+logic
logic/core_pkg.sv
logic/inst_decoder.sv
logic/inst_queue.sv
logic/alu_exec.sv
logic/reg_writeback.sv
logic/issue_core.sv
verif/issue_core_checker.sv
verif/issue_core_tb.sv

// ==== logic/alu_exec.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu_exec import core_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          dec_inst_t issue_inst,
    input  wire          issued,
    output reg_addr_t    rs1_addr,
    output reg_addr_t    rs2_addr,
    input  wire   [31:0] rs1_data,
    input  wire   [31:0] rs2_data,
    output exec_result_t ex_result
);

    logic [31:0] opa;
    logic [31:0] opb;
    logic [4:0]  shamt;
    logic [31:0] value;

    assign rs1_addr = issue_inst.rs1;
    assign rs2_addr = issue_inst.rs2;

    assign opa   = rs1_data;
    assign opb   = issue_inst.has_imm ? issue_inst.imm : rs2_data;
    assign shamt = opb[4:0];

    always_comb begin
        case (issue_inst.op)
            op_add:  value = opa + opb;
            op_sub:  value = opa - opb;
            op_and:  value = opa & opb;
            op_or:   value = opa | opb;
            op_xor:  value = opa ^ opb;
            op_sll:  value = opa << shamt;
            op_srl:  value = opa >> shamt;
            op_sra:  value = $unsigned($signed(opa) >>> shamt);
            op_slt:  value = {31'b0, $signed(opa) < $signed(opb)};
            op_sltu: value = {31'b0, opa < opb};
            op_lui:  value = issue_inst.imm; // upper immediate passes unchanged.
            default: value = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            ex_result.valid <= 1'b0;
        end else begin
            ex_result.valid <= issued;
            ex_result.rd    <= issue_inst.rd;
            ex_result.value <= value;
        end
    end

endmodule

`default_nettype wire

// ==== logic/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// Sizes and fixed codes shared by the core and its testbench.

// Number of entries in the circular instruction queue.
// This must stay a power of two so the pointers wrap on their own.
`define CORE_IQ_DEPTH 16

// Number of architectural integer registers.
// Register zero is hardwired to zero.
`define CORE_NUM_REGS 32

// Decoded operation code for an empty slot or an unsupported encoding.
// An op with this code is never written into the queue.
`define CORE_OP_NOP 5'b11111

`endif

// ==== logic/core_pkg.sv ====
`default_nettype none

`include "core_defs.svh"

package core_pkg;

    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_addr_t;

    // immediate forms reuse these codes and set has_imm.
    typedef enum logic [4:0] {
        op_add  = 5'd0,
        op_sub  = 5'd1,
        op_and  = 5'd2,
        op_or   = 5'd3,
        op_xor  = 5'd4,
        op_sll  = 5'd5,
        op_srl  = 5'd6,
        op_sra  = 5'd7,
        op_slt  = 5'd8,
        op_sltu = 5'd9,
        op_lui  = 5'd10,
        op_nop  = `CORE_OP_NOP
    } op_e;

    typedef enum logic [1:0] {
        empty,
        partial,
        full
    } iq_state_e;

    typedef struct packed {
        op_e        op;
        reg_addr_t  rs1;
        reg_addr_t  rs2;
        reg_addr_t  rd;
        logic [31:0] imm;
        logic       has_imm;
    } dec_inst_t;

    typedef struct packed {
        logic        valid;
        reg_addr_t   rd;
        logic [31:0] value;
    } exec_result_t;

endpackage

`default_nettype wire

// ==== logic/inst_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module inst_decoder import core_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         inst_valid,
    input  wire  [31:0] inst,
    output dec_inst_t   dec
);

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    dec_inst_t   nxt;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];
    assign imm_i  = {{20{inst[31]}}, inst[31:20]};
    assign imm_u  = {inst[31:12], 12'b0};

    always_comb begin
        nxt.op      = op_nop;
        nxt.rs1     = inst[19:15];
        nxt.rs2     = inst[24:20];
        nxt.rd      = inst[11:7];
        nxt.imm     = imm_i;
        nxt.has_imm = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_BASE) begin
                    case (funct3)
                        3'b000: nxt.op = op_add;
                        3'b001: nxt.op = op_sll;
                        3'b010: nxt.op = op_slt;
                        3'b011: nxt.op = op_sltu;
                        3'b100: nxt.op = op_xor;
                        3'b101: nxt.op = op_srl;
                        3'b110: nxt.op = op_or;
                        default: nxt.op = op_and;
                    endcase
                end else if (funct7 == F7_ALT && funct3 == 3'b000) begin
                    nxt.op = op_sub;
                end else if (funct7 == F7_ALT && funct3 == 3'b101) begin
                    nxt.op = op_sra;
                end
            end
            OPC_OP_IMM: begin
                nxt.has_imm = 1'b1;
                case (funct3)
                    3'b000: nxt.op = op_add;
                    3'b010: nxt.op = op_slt;
                    3'b011: nxt.op = op_sltu;
                    3'b100: nxt.op = op_xor;
                    3'b110: nxt.op = op_or;
                    3'b111: nxt.op = op_and;
                    3'b001: nxt.op = (funct7 == F7_BASE) ? op_sll : op_nop;
                    default: begin
                        if (funct7 == F7_BASE) nxt.op = op_srl;
                        else if (funct7 == F7_ALT) nxt.op = op_sra;
                    end
                endcase
            end
            OPC_LUI: begin
                nxt.op      = op_lui;
                nxt.rs1     = '0; // lui has no source register.
                nxt.imm     = imm_u;
                nxt.has_imm = 1'b1;
            end
            default: nxt.op = op_nop;
        endcase
        if (!inst_valid) nxt.op = op_nop;
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            dec.op <= op_nop;
        end else begin
            dec <= nxt;
        end
    end

endmodule

`default_nettype wire

// ==== logic/inst_queue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module inst_queue import core_pkg::*; (
    input  wire        clk,
    input  wire        rst,
    input  wire        dec_inst_t dec,
    input  wire        rs_full,
    input  wire        rob_full,
    output logic       iq_full,
    output logic       issued,
    output dec_inst_t  issue_inst
);

    localparam int DEPTH = `CORE_IQ_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    dec_inst_t        entries [DEPTH];
    logic [DEPTH-1:0] busy;
    logic [PTR_W-1:0] head;
    logic [PTR_W-1:0] tail;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_nxt;
    iq_state_e        state;
    iq_state_e        state_nxt;
    logic             stall;
    logic             wr_req;
    logic             bypass;
    logic             enq;
    logic             deq;

    assign stall   = rs_full || rob_full;
    assign wr_req  = (dec.op != op_nop);
    // an empty queue hands the new op straight to execute.
    assign bypass  = wr_req && (state == empty) && !stall;
    assign enq     = wr_req && !bypass;
    assign deq     = busy[head] && !stall;
    assign iq_full = (state == full);

    always_comb begin
        count_nxt = count;
        if (enq && !deq) begin
            count_nxt = count + 1'b1;
        end else if (deq && !enq) begin
            count_nxt = count - 1'b1;
        end
        if (count_nxt == '0) begin
            state_nxt = empty;
        end else if (count_nxt >= CNT_W'(DEPTH - 1)) begin
            state_nxt = full; // one slot stays for an op already in decode.
        end else begin
            state_nxt = partial;
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            entries[tail] <= dec;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            head          <= '0;
            tail          <= '0;
            busy          <= '0;
            count         <= '0;
            state         <= empty;
            issued        <= 1'b0;
            issue_inst.op <= op_nop;
        end else begin
            if (deq) begin
                busy[head] <= 1'b0;
                head       <= head + 1'b1;
            end
            if (enq) begin
                busy[tail] <= 1'b1;
                tail       <= tail + 1'b1;
            end
            count  <= count_nxt;
            state  <= state_nxt;
            issued <= deq || bypass;
            if (deq) begin
                issue_inst <= entries[head];
            end else if (bypass) begin
                issue_inst <= dec;
            end else begin
                issue_inst.op <= op_nop;
            end
        end
    end

    // the source must hold inst_valid back while iq_full is high.
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst)
        enq |-> count != CNT_W'(DEPTH))
        else $error("inst_queue write with all %0d entries busy", DEPTH);

    a_issue_stall: assert property (@(posedge clk) disable iff (!rst)
        issued |-> !$past(rs_full) && !$past(rob_full))
        else $error("inst_queue issued under back-pressure");

endmodule

`default_nettype wire

// ==== logic/issue_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_core import core_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          inst_valid,
    input  wire   [31:0] inst,
    input  wire          rs_full,
    input  wire          rob_full,
    output logic         iq_full,
    output logic         issued,
    output exec_result_t result
);

    dec_inst_t    dec;
    dec_inst_t    issue_inst;
    reg_addr_t    rs1_addr;
    reg_addr_t    rs2_addr;
    logic [31:0]  rs1_data;
    logic [31:0]  rs2_data;
    exec_result_t ex_result;

    inst_decoder u_decoder (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec        (dec)
    );

    inst_queue u_queue (
        .clk        (clk),
        .rst        (rst),
        .dec        (dec),
        .rs_full    (rs_full),
        .rob_full   (rob_full),
        .iq_full    (iq_full),
        .issued     (issued),
        .issue_inst (issue_inst)
    );

    alu_exec u_exec (
        .clk        (clk),
        .rst        (rst),
        .issue_inst (issue_inst),
        .issued     (issued),
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .ex_result  (ex_result)
    );

    reg_writeback u_writeback (
        .clk       (clk),
        .rst       (rst),
        .ex_result (ex_result),
        .rs1_addr  (rs1_addr),
        .rs2_addr  (rs2_addr),
        .rs1_data  (rs1_data),
        .rs2_data  (rs2_data),
        .result    (result)
    );

endmodule

`default_nettype wire

// ==== logic/reg_writeback.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module reg_writeback import core_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          exec_result_t ex_result,
    input  wire          reg_addr_t rs1_addr,
    input  wire          reg_addr_t rs2_addr,
    output logic  [31:0] rs1_data,
    output logic  [31:0] rs2_data,
    output exec_result_t result
);

    logic [31:0] regs [`CORE_NUM_REGS];
    logic        wr_en;

    assign wr_en = ex_result.valid && (ex_result.rd != '0);

    // the op in execute reads the result that is written this cycle.
    function automatic logic [31:0] read_port(input reg_addr_t addr);
        if (addr == '0) return '0;
        if (wr_en && ex_result.rd == addr) return ex_result.value;
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ex_result.rd] <= ex_result.value;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            result.valid <= 1'b0;
        end else begin
            result.valid <= ex_result.valid;
            result.rd    <= ex_result.rd;
            result.value <= (ex_result.rd == '0) ? '0 : ex_result.value;
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module issue_core_tb \
    -f issue_core.f -o sim_issue_core
./obj_dir/sim_issue_core > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    exit 1
fi
grep -q "TEST RESULT: PASS" sim.log

// ==== verif/issue_core_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "core_defs.svh"

module issue_core_checker import core_pkg::*; (
    input  wire          clk,
    input  wire          rst,
    input  wire          inst_valid,
    input  wire   [31:0] inst,
    input  wire          rs_full,
    input  wire          rob_full,
    input  wire          iq_full,
    input  wire          issued,
    input  wire          exec_result_t result,
    output int           error_count,
    output int           result_count,
    output int           pending
);

    logic [31:0] model [`CORE_NUM_REGS];
    logic [31:0] expected_q [$];
    logic        prev_stall;
    int          stalled_accepts;
    logic        seen_full;

    // RV32I OP, OP-IMM and LUI are the only groups the core accepts.
    function automatic bit is_supported(input logic [31:0] w);
        case (w[6:0])
            7'b0110011: return w[31:25] == 7'h00 ||
                (w[31:25] == 7'h20 && (w[14:12] == 3'd0 || w[14:12] == 3'd5));
            7'b0010011: begin
                if (w[14:12] == 3'd1) return w[31:25] == 7'h00;
                if (w[14:12] == 3'd5) return w[31:25] == 7'h00 || w[31:25] == 7'h20;
                return 1'b1;
            end
            7'b0110111: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] expect_value(input logic [31:0] w);
        logic [31:0] a;
        logic [31:0] b;
        logic        is_imm;
        logic        alt;
        is_imm = (w[6:0] == 7'b0010011);
        a = model[w[19:15]];
        b = is_imm ? {{20{w[31]}}, w[31:20]} : model[w[24:20]];
        alt = w[30] && (!is_imm || w[14:12] == 3'd5); // sub and sra.
        if (w[6:0] == 7'b0110111) return {w[31:12], 12'b0};
        case (w[14:12])
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    assign pending = expected_q.size();

    always @(posedge clk) begin
        logic [31:0] w;
        logic [31:0] exp_value;
        logic        stall_now;
        if (!rst) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) model[i] = '0;
            expected_q.delete();
            prev_stall      <= 1'b0;
            stalled_accepts = 0;
            seen_full       = 1'b0;
        end else begin
            stall_now = rs_full || rob_full;
            if (issued && prev_stall) begin
                $display("issue pulse seen while back-pressure was applied");
                error_count++;
            end
            prev_stall <= stall_now;
            if (stall_now) begin
                if (inst_valid) stalled_accepts++;
                if (iq_full) seen_full = 1'b1;
            end else begin
                if (stalled_accepts >= 15 && !seen_full) begin
                    $display("queue never reported full after %0d stalled entries",
                        stalled_accepts);
                    error_count++;
                end
                stalled_accepts = 0;
                seen_full       = 1'b0;
            end
            if (result.valid) begin
                result_count++;
                if (expected_q.size() == 0) begin
                    $display("result appeared with no instruction outstanding");
                    error_count++;
                end else begin
                    w = expected_q.pop_front();
                    exp_value = (w[11:7] == 5'd0) ? 32'h0 : expect_value(w);
                    if (result.rd != w[11:7]) begin
                        $display("ERROR result.rd got %h expected %h", result.rd, w[11:7]);
                        error_count++;
                    end
                    if (result.value !== exp_value) begin
                        $display("ERROR result.value got %h expected %h (inst %h)",
                            result.value, exp_value, w);
                        error_count++;
                    end
                    if (w[11:7] != 5'd0) model[w[11:7]] = exp_value;
                end
            end
            if (inst_valid && is_supported(inst)) expected_q.push_back(inst);
        end
    end

endmodule

`default_nettype wire

// ==== verif/issue_core_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_core_tb import core_pkg::*;;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        logic [31:0] inst;
        logic        valid;
        logic        rs_full;
        logic        rob_full;
        logic        supported;
    } stim_t;

    logic         clk;
    logic         rst;
    logic         inst_valid;
    logic [31:0]  inst;
    logic         rs_full;
    logic         rob_full;
    logic         iq_full;
    logic         issued;
    exec_result_t result;
    int           error_count;
    int           result_count;
    int           pending;
    stim_t        rows [$];
    logic [31:0]  seed;
    int           expected_results;
    int           tb_errors;
    bit           timed_out;

    issue_core uut (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .rs_full(rs_full),
        .rob_full(rob_full), .iq_full(iq_full), .issued(issued), .result(result)
    );

    issue_core_checker u_checker (
        .clk(clk), .rst(rst), .inst_valid(inst_valid), .inst(inst), .rs_full(rs_full),
        .rob_full(rob_full), .iq_full(iq_full), .issued(issued), .result(result),
        .error_count(error_count), .result_count(result_count), .pending(pending)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function logic [31:0] next_rand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    task add_row(input logic [31:0] w, input logic v, input logic rsf, input logic robf,
                 input logic sup);
        rows.push_back({w, v, rsf, robf, sup});
    endtask

    // draws only supported encodings and gives shifts a valid shamt field.
    function logic [31:0] rand_inst();
        int          kind;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        kind = (next_rand() >> 8) % 20;
        rd   = 5'(next_rand() >> 20);
        rs1  = 5'(next_rand() >> 20);
        rs2  = 5'(next_rand() >> 20);
        imm  = 12'(next_rand() >> 16);
        if (kind < 8) return enc_r(7'h00, rs2, rs1, 3'(kind), rd);
        if (kind == 8) return enc_r(7'h20, rs2, rs1, 3'd0, rd);
        if (kind == 9) return enc_r(7'h20, rs2, rs1, 3'd5, rd);
        if (kind == 11 || kind == 15) return enc_i({7'h00, imm[4:0]}, rs1, 3'(kind - 10), rd);
        if (kind < 18) return enc_i(imm, rs1, 3'(kind - 10), rd);
        if (kind == 18) return enc_i({7'h20, imm[4:0]}, rs1, 3'd5, rd);
        return enc_lui(20'(next_rand() >> 12), rd);
    endfunction

    task build_table();
        add_row(enc_lui(20'h12345, 5'd1), 1, 0, 0, 1);
        add_row(enc_i(12'h678, 5'd1, 3'd0, 5'd1), 1, 0, 0, 1); // depends on the lui.
        add_row(enc_i(12'hffd, 5'd0, 3'd0, 5'd2), 1, 0, 0, 1);
        for (int f = 0; f < 8; f++) add_row(enc_r(7'h00, 5'd2, 5'd1, 3'(f), 5'(3 + f)), 1, 0, 0, 1);
        add_row(enc_r(7'h20, 5'd2, 5'd1, 3'd0, 5'd11), 1, 0, 0, 1);
        add_row(enc_r(7'h20, 5'd11, 5'd2, 3'd5, 5'd12), 1, 0, 0, 1);
        add_row(enc_i(12'h001, 5'd2, 3'd2, 5'd13), 1, 0, 0, 1);
        add_row(enc_i(12'h001, 5'd2, 3'd3, 5'd14), 1, 0, 0, 1);
        add_row(enc_i(12'hfff, 5'd1, 3'd4, 5'd15), 1, 0, 0, 1);
        add_row(enc_i(12'h0f0, 5'd1, 3'd6, 5'd16), 1, 0, 0, 1);
        add_row(enc_i(12'h0ff, 5'd1, 3'd7, 5'd17), 1, 0, 0, 1);
        add_row(enc_i(12'h004, 5'd1, 3'd1, 5'd18), 1, 0, 0, 1);
        add_row(enc_i(12'h004, 5'd2, 3'd5, 5'd19), 1, 0, 0, 1);
        add_row(enc_i(12'h404, 5'd2, 3'd5, 5'd20), 1, 0, 0, 1);
        add_row(enc_i(12'h007, 5'd1, 3'd0, 5'd0), 1, 0, 0, 1);
        add_row(enc_r(7'h00, 5'd1, 5'd0, 3'd0, 5'd21), 1, 0, 0, 1);
        add_row(32'h0000_2083, 1, 0, 0, 0); // a load.
        add_row(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd5), 1, 0, 0, 0);
        add_row(enc_i(12'h404, 5'd1, 3'd1, 5'd6), 1, 0, 0, 0);
        add_row(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd7), 0, 0, 0, 1);
        for (int k = 0; k < 4; k++) add_row(32'h0, 0, 0, 0, 0);
        for (int k = 0; k < 15; k++) add_row(enc_i(12'h001, 5'd22, 3'd0, 5'd22), 1, 1, 0, 1);
        for (int k = 0; k < 3; k++) add_row(32'h0, 0, 1, 0, 0);
        // the held entries drain before the next back-pressure phase.
        for (int k = 0; k < 16; k++) add_row(32'h0, 0, 0, 0, 0);
        for (int k = 0; k < 3; k++) add_row(enc_r(7'h00, 5'd22, 5'd23, 3'd0, 5'd23), 1, 0, 1, 1);
        add_row(32'h0, 0, 0, 0, 0);
        for (int k = 0; k < 40; k++) add_row(rand_inst(), 1, 0, 0, 1);
    endtask

    task apply_row(input stim_t s);
        int waited;
        waited     = 0;
        inst_valid = 1'b0;
        rs_full    = s.rs_full;
        rob_full   = s.rob_full;
        while (s.valid && iq_full && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (s.valid && iq_full) begin
            $display("timed out waiting for the queue to leave the full state");
            timed_out = 1'b1;
        end else begin
            inst_valid = s.valid;
            inst       = s.inst;
            if (s.valid && s.supported) expected_results++;
            @(posedge clk);
            #1;
        end
    endtask

    task drain_pipeline();
        int waited;
        waited     = 0;
        inst_valid = 1'b0;
        rs_full    = 1'b0;
        rob_full   = 1'b0;
        while (pending != 0 && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (pending != 0) begin
            $display("%0d results never appeared", pending);
            timed_out = 1'b1;
        end
        repeat (6) @(posedge clk);
    endtask

    task finish_run();
        if (result_count != expected_results) begin
            $display("result count %0d differs from %0d supported instructions",
                result_count, expected_results);
            tb_errors++;
        end
        $display("%0d results, %0d checker errors, %0d testbench errors",
            result_count, error_count, tb_errors);
        if (error_count != 0 || tb_errors != 0 || timed_out) begin
            $display("TEST RESULT: FAIL");
        end else begin
            $display("TEST RESULT: PASS");
        end
        $finish;
    endtask

    initial begin
        rst = 1'b0;
        inst_valid = 1'b0;
        inst = 32'h0;
        rs_full = 1'b0;
        rob_full = 1'b0;
        seed = 32'd95806;
        expected_results = 0;
        tb_errors = 0;
        timed_out = 1'b0;
        build_table();
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b1;
        foreach (rows[i]) begin
            if (!timed_out) apply_row(rows[i]);
        end
        if (!timed_out) drain_pipeline();
        finish_run();
    end

endmodule

`default_nettype wire
